/* rtl/snow64_mem_cfg.svh */
`ifndef SNOW64_MEM_CFG_SVH
`define SNOW64_MEM_CFG_SVH

// width of a line address.
`define SNOW64_MEM_ADDR_W 32

// width of one memory line.
`define SNOW64_MEM_DATA_W 64

// bus requests that may await a response at once.
// The order queue is sized from this.
`define SNOW64_MEM_MAX_OUTSTANDING 4

`endif

/* rtl/pkg_snow64_mem.sv */
`default_nettype none

`include "snow64_mem_cfg.svh"

package pkg_snow64_mem;

	typedef logic [`SNOW64_MEM_ADDR_W-1:0] addr_t;
	typedef logic [`SNOW64_MEM_DATA_W-1:0] data_t;

	// instruction cache line read.
	typedef struct packed {
		addr_t addr;
	} instr_req_t;

	// lar file request, same shape as the bus request.
	typedef struct packed {
		logic write;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

	// zero for a write acknowledgement.
	typedef struct packed {
		data_t rdata;
	} mem_resp_t;

	// owner of an issued request.
	typedef enum logic {
		src_instr = 1'b0,
		src_lar = 1'b1
	} src_t;

endpackage

`default_nettype wire

/* rtl/snow64_skid_stage.sv */
`default_nettype none

module snow64_skid_stage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	logic skid_valid;
	payload_t skid_data;
	logic in_fire;
	logic main_load;

	// ready only depends on the skid register.
	assign in_ready = !skid_valid;
	assign in_fire = in_valid && in_ready;
	assign main_load = !out_valid || out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_load) begin
			if (skid_valid) begin
				out_valid <= 1'b1;
				skid_valid <= 1'b0;
			end else begin
				out_valid <= in_fire;
			end
		end else if (in_fire) begin
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (main_load) begin
			out_data <= skid_valid ? skid_data : in_data;
		end
		if (!main_load && in_fire) begin
			skid_data <= in_data;
		end
	end

	a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("skid stage output changed while stalled.");

endmodule

`default_nettype wire

/* rtl/snow64_mem_bus_guard.sv */
`default_nettype none

module snow64_mem_bus_guard (
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	output logic instr_ready,
	input pkg_snow64_mem::instr_req_t instr_req,
	input logic lar_valid,
	output logic lar_ready,
	input pkg_snow64_mem::mem_req_t lar_req,
	output logic bus_req_valid,
	input logic bus_req_ready,
	output pkg_snow64_mem::mem_req_t bus_req,
	output logic push,
	output pkg_snow64_mem::src_t push_src,
	input logic queue_full
);

	import pkg_snow64_mem::*;

	src_t last_grant;
	src_t held_src;
	logic held;
	src_t grant;
	logic bus_fire;

	// an offer stalled by the bus keeps its source.
	always_comb begin
		if (held) begin
			grant = held_src;
		end else if (instr_valid && lar_valid) begin
			grant = (last_grant == src_instr) ? src_lar : src_instr;
		end else if (lar_valid) begin
			grant = src_lar;
		end else begin
			grant = src_instr;
		end
	end

	assign bus_req_valid = (instr_valid || lar_valid) && !queue_full;
	assign bus_fire = bus_req_valid && bus_req_ready;

	// instruction fetch becomes a plain read.
	always_comb begin
		if (grant == src_lar) begin
			bus_req = lar_req;
		end else begin
			bus_req.write = 1'b0;
			bus_req.addr = instr_req.addr;
			bus_req.wdata = '0;
		end
	end

	assign instr_ready = bus_req_ready && !queue_full && (grant == src_instr);
	assign lar_ready = bus_req_ready && !queue_full && (grant == src_lar);

	assign push = bus_fire;
	assign push_src = grant;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_grant <= src_lar;
			held <= 1'b0;
			held_src <= src_instr;
		end else begin
			held <= bus_req_valid && !bus_req_ready;
			held_src <= grant;
			if (bus_fire) begin
				last_grant <= grant;
			end
		end
	end

	a_bus_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
		bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req))
		else $error("bus request changed under back-pressure.");

endmodule

`default_nettype wire

/* rtl/snow64_resp_router.sv */
`default_nettype none

`include "snow64_mem_cfg.svh"

module snow64_resp_router (
	input logic clk,
	input logic arst_n,
	input logic push,
	input pkg_snow64_mem::src_t push_src,
	output logic queue_full,
	input logic bus_resp_valid,
	output logic bus_resp_ready,
	input pkg_snow64_mem::mem_resp_t bus_resp,
	output logic instr_valid,
	input logic instr_ready,
	output pkg_snow64_mem::mem_resp_t instr_resp,
	output logic lar_valid,
	input logic lar_ready,
	output pkg_snow64_mem::mem_resp_t lar_resp
);

	import pkg_snow64_mem::*;

	localparam int unsigned DEPTH = `SNOW64_MEM_MAX_OUTSTANDING;
	localparam int unsigned IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	src_t order_q [DEPTH];
	logic [IDX_W-1:0] wr_ptr;
	logic [IDX_W-1:0] rd_ptr;
	logic [IDX_W:0] count;
	logic empty;
	src_t head;
	logic pop;

	function automatic logic [IDX_W-1:0] ptr_inc(input logic [IDX_W-1:0] ptr);
		if (ptr == IDX_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign queue_full = (count == (IDX_W + 1)'(DEPTH));
	assign head = order_q[rd_ptr];

	// oldest issued request owns the response.
	assign bus_resp_ready = !empty && ((head == src_instr) ? instr_ready : lar_ready);
	assign instr_valid = bus_resp_valid && !empty && (head == src_instr);
	assign lar_valid = bus_resp_valid && !empty && (head == src_lar);
	assign instr_resp = bus_resp;
	assign lar_resp = bus_resp;
	assign pop = bus_resp_valid && bus_resp_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			order_q[wr_ptr] <= push_src;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	a_resp_has_owner: assert property (@(posedge clk) disable iff (!arst_n)
		bus_resp_valid |-> !empty)
		else $error("bus response with no outstanding request.");

endmodule

`default_nettype wire

/* rtl/snow64_mem_accessors.sv */
`default_nettype none

module snow64_mem_accessors (
	input logic clk,
	input logic arst_n,
	input logic instr_req_valid,
	output logic instr_req_ready,
	input pkg_snow64_mem::instr_req_t instr_req,
	output logic instr_resp_valid,
	input logic instr_resp_ready,
	output pkg_snow64_mem::mem_resp_t instr_resp,
	input logic lar_req_valid,
	output logic lar_req_ready,
	input pkg_snow64_mem::mem_req_t lar_req,
	output logic lar_resp_valid,
	input logic lar_resp_ready,
	output pkg_snow64_mem::mem_resp_t lar_resp,
	output logic bus_req_valid,
	input logic bus_req_ready,
	output pkg_snow64_mem::mem_req_t bus_req,
	input logic bus_resp_valid,
	output logic bus_resp_ready,
	input pkg_snow64_mem::mem_resp_t bus_resp
);

	import pkg_snow64_mem::*;

	logic instr_req_q_valid;
	logic instr_req_q_ready;
	instr_req_t instr_req_q;
	logic lar_req_q_valid;
	logic lar_req_q_ready;
	mem_req_t lar_req_q;
	logic instr_resp_r_valid;
	logic instr_resp_r_ready;
	mem_resp_t instr_resp_r;
	logic lar_resp_r_valid;
	logic lar_resp_r_ready;
	mem_resp_t lar_resp_r;
	logic push;
	src_t push_src;
	logic queue_full;

	snow64_skid_stage #(.payload_t(instr_req_t)) instr_req_skid_inst (
		.clk(clk), .arst_n(arst_n),
		.in_valid(instr_req_valid), .in_ready(instr_req_ready), .in_data(instr_req),
		.out_valid(instr_req_q_valid), .out_ready(instr_req_q_ready),
		.out_data(instr_req_q)
	);

	snow64_skid_stage #(.payload_t(mem_req_t)) lar_req_skid_inst (
		.clk(clk), .arst_n(arst_n),
		.in_valid(lar_req_valid), .in_ready(lar_req_ready), .in_data(lar_req),
		.out_valid(lar_req_q_valid), .out_ready(lar_req_q_ready), .out_data(lar_req_q)
	);

	snow64_mem_bus_guard mem_bus_guard_inst (
		.clk(clk), .arst_n(arst_n),
		.instr_valid(instr_req_q_valid), .instr_ready(instr_req_q_ready),
		.instr_req(instr_req_q),
		.lar_valid(lar_req_q_valid), .lar_ready(lar_req_q_ready), .lar_req(lar_req_q),
		.bus_req_valid(bus_req_valid), .bus_req_ready(bus_req_ready), .bus_req(bus_req),
		.push(push), .push_src(push_src), .queue_full(queue_full)
	);

	snow64_resp_router resp_router_inst (
		.clk(clk), .arst_n(arst_n),
		.push(push), .push_src(push_src), .queue_full(queue_full),
		.bus_resp_valid(bus_resp_valid), .bus_resp_ready(bus_resp_ready),
		.bus_resp(bus_resp),
		.instr_valid(instr_resp_r_valid), .instr_ready(instr_resp_r_ready),
		.instr_resp(instr_resp_r),
		.lar_valid(lar_resp_r_valid), .lar_ready(lar_resp_r_ready), .lar_resp(lar_resp_r)
	);

	snow64_skid_stage #(.payload_t(mem_resp_t)) instr_resp_skid_inst (
		.clk(clk), .arst_n(arst_n),
		.in_valid(instr_resp_r_valid), .in_ready(instr_resp_r_ready),
		.in_data(instr_resp_r),
		.out_valid(instr_resp_valid), .out_ready(instr_resp_ready), .out_data(instr_resp)
	);

	snow64_skid_stage #(.payload_t(mem_resp_t)) lar_resp_skid_inst (
		.clk(clk), .arst_n(arst_n),
		.in_valid(lar_resp_r_valid), .in_ready(lar_resp_r_ready), .in_data(lar_resp_r),
		.out_valid(lar_resp_valid), .out_ready(lar_resp_ready), .out_data(lar_resp)
	);

endmodule

`default_nettype wire

/* dv/snow64_clk_gen.sv */
`default_nettype none

module snow64_clk_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
	end

	// toggles every half period.
	always begin
		#(PERIOD_NS / 2.0);
		clk = ~clk;
	end

endmodule

`default_nettype wire

/* dv/tb_snow64_mem_accessors.sv */
`default_nettype none

`include "snow64_mem_cfg.svh"

module tb_snow64_mem_accessors;

	timeunit 1ns;
	timeprecision 100ps;

	import pkg_snow64_mem::*;

	localparam int MAX_OUT = `SNOW64_MEM_MAX_OUTSTANDING;
	localparam int NUM_RANDOM = 400;
	localparam int NUM_HOLD = 12;
	localparam int NUM_FAIR = 60;
	localparam int NUM_REQS = 2 + NUM_RANDOM + NUM_HOLD + NUM_FAIR;
	localparam int TIMEOUT_CYCLES = 10 * NUM_REQS + 200;

	typedef struct packed {
		logic write;
		addr_t addr;
		data_t data;
	} entry_t;

	typedef struct packed {
		logic [31:0] due;
		data_t data;
	} bus_slot_t;

	logic clk;
	logic arst_n;
	logic instr_req_valid;
	logic instr_req_ready;
	instr_req_t instr_req;
	logic instr_resp_valid;
	logic instr_resp_ready;
	mem_resp_t instr_resp;
	logic lar_req_valid;
	logic lar_req_ready;
	mem_req_t lar_req;
	logic lar_resp_valid;
	logic lar_resp_ready;
	mem_resp_t lar_resp;
	logic bus_req_valid;
	logic bus_req_ready;
	mem_req_t bus_req;
	logic bus_resp_valid;
	logic bus_resp_ready;
	mem_resp_t bus_resp;

	logic [31:0] rng_state = 32'h1c46;
	int unsigned cycle_count = 0;
	data_t tb_mem [addr_t];
	data_t model_mem [addr_t];
	entry_t instr_exp [$];
	entry_t lar_exp [$];
	bus_slot_t bus_pend [$];
	addr_t instr_plan [$];
	mem_req_t lar_plan [$];
	int instr_to_send = 0;
	int lar_to_send = 0;
	bit instr_taken = 0;
	bit lar_taken = 0;
	bit resp_taken = 0;
	bit noisy = 0;
	bit withhold = 0;
	bit reads_only = 0;
	bit fair_mode = 0;
	int fair_run = 0;
	src_t fair_last = src_instr;
	bit bus_stall = 0;
	bit instr_stall = 0;
	bit lar_stall = 0;
	mem_req_t bus_req_prev;
	mem_resp_t instr_resp_prev;
	mem_resp_t lar_resp_prev;

	snow64_clk_gen clk_gen_inst (.clk(clk));

	snow64_mem_accessors snow64_mem_accessors_inst (.*);

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// contents of a line that was never written.
	function automatic data_t line_fill(input addr_t addr);
		return {~addr, addr ^ 32'h9e37_79b9};
	endfunction

	function automatic bit addr_in_flight(input entry_t q[$], input addr_t addr,
			input bit writes_only);
		foreach (q[i]) begin
			if (q[i].addr == addr && (q[i].write || !writes_only)) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic bit traffic_pending();
		return instr_to_send > 0 || lar_to_send > 0 || instr_plan.size() > 0
			|| lar_plan.size() > 0 || instr_req_valid || lar_req_valid
			|| instr_exp.size() > 0 || lar_exp.size() > 0 || bus_pend.size() > 0;
	endfunction

	task automatic report_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string reason);
		$display("** Error at %0t ns: %s", $time, reason);
		report_failure();
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name,
				actual, expected);
			report_failure();
		end
	endtask

	task automatic drive_requests();
		addr_t addr;
		mem_req_t req;
		logic [31:0] r;
		if (!instr_req_valid || instr_taken) begin
			instr_taken = 1'b0;
			instr_req_valid = 1'b0;
			r = next_rand();
			addr = fair_mode ? addr_t'(32'h100 + r[2:0]) : addr_t'(r[2:0]);
			if (instr_plan.size() > 0) begin
				instr_req_valid = 1'b1;
				instr_req.addr = instr_plan.pop_front();
			end else if (instr_to_send > 0 && (fair_mode || r[9:8] != 2'd0)
					&& !addr_in_flight(lar_exp, addr, 1'b1)
					&& !(lar_req_valid && !lar_taken && lar_req.write
					&& lar_req.addr == addr)) begin
				instr_req_valid = 1'b1;
				instr_req.addr = addr;
				instr_to_send--;
			end
		end
		if (!lar_req_valid || lar_taken) begin
			lar_taken = 1'b0;
			lar_req_valid = 1'b0;
			r = next_rand();
			req.write = r[4] && !reads_only;
			req.addr = fair_mode ? addr_t'(32'h200 + r[2:0]) : addr_t'(r[2:0]);
			req.wdata = {next_rand(), next_rand()};
			// a write may not overtake an instruction read of the same line.
			if (req.write && (addr_in_flight(instr_exp, req.addr, 1'b0)
					|| (instr_req_valid && instr_req.addr == req.addr))) begin
				req.write = 1'b0;
			end
			if (lar_plan.size() > 0) begin
				lar_req_valid = 1'b1;
				lar_req = lar_plan.pop_front();
			end else if (lar_to_send > 0 && (fair_mode || r[9:8] != 2'd0)) begin
				lar_req_valid = 1'b1;
				lar_req = req;
				lar_to_send--;
			end
		end
	endtask

	task automatic drive_bus();
		logic [31:0] r;
		r = next_rand();
		bus_req_ready = !noisy || r[1:0] != 2'd0;
		instr_resp_ready = !noisy || r[3:2] != 2'd0;
		lar_resp_ready = !noisy || r[5:4] != 2'd0;
		if (!bus_resp_valid || resp_taken) begin
			resp_taken = 1'b0;
			bus_resp_valid = 1'b0;
			if (bus_pend.size() > 0 && !withhold && cycle_count >= bus_pend[0].due) begin
				bus_resp_valid = 1'b1;
				bus_resp.rdata = bus_pend[0].data;
			end
		end
	endtask

	task automatic check_stalls();
		if (bus_stall) begin
			check_value("bus_req_valid", bus_req_valid, 1'b1);
			check_value("bus_req", bus_req, bus_req_prev);
		end
		if (instr_stall) begin
			check_value("instr_resp_valid", instr_resp_valid, 1'b1);
			check_value("instr_resp", instr_resp, instr_resp_prev);
		end
		if (lar_stall) begin
			check_value("lar_resp_valid", lar_resp_valid, 1'b1);
			check_value("lar_resp", lar_resp, lar_resp_prev);
		end
		bus_stall = bus_req_valid && !bus_req_ready;
		bus_req_prev = bus_req;
		instr_stall = instr_resp_valid && !instr_resp_ready;
		instr_resp_prev = instr_resp;
		lar_stall = lar_resp_valid && !lar_resp_ready;
		lar_resp_prev = lar_resp;
	endtask

	task automatic sample_requests();
		entry_t e;
		bus_slot_t slot;
		src_t src;
		logic [31:0] r;
		if (instr_req_valid && instr_req_ready) begin
			instr_taken = 1'b1;
			e.write = 1'b0;
			e.addr = instr_req.addr;
			e.data = model_mem.exists(e.addr) ? model_mem[e.addr] : line_fill(e.addr);
			instr_exp.push_back(e);
		end
		if (lar_req_valid && lar_req_ready) begin
			lar_taken = 1'b1;
			e.write = lar_req.write;
			e.addr = lar_req.addr;
			if (lar_req.write) begin
				model_mem[e.addr] = lar_req.wdata;
				e.data = '0;
			end else begin
				e.data = model_mem.exists(e.addr) ? model_mem[e.addr] : line_fill(e.addr);
			end
			lar_exp.push_back(e);
		end
		if (bus_req_valid && bus_req_ready) begin
			if (bus_pend.size() >= MAX_OUT) begin
				abort_run("bus accepted a request beyond the outstanding limit");
			end
			r = next_rand();
			slot.due = cycle_count + 1 + r[1:0];
			if (bus_req.write) begin
				tb_mem[bus_req.addr] = bus_req.wdata;
				slot.data = '0;
			end else if (tb_mem.exists(bus_req.addr)) begin
				slot.data = tb_mem[bus_req.addr];
			end else begin
				slot.data = line_fill(bus_req.addr);
			end
			bus_pend.push_back(slot);
			// fetches reach the bus as reads with no write data.
			if (fair_mode && !bus_req.addr[9]) begin
				check_value("bus_req.write", bus_req.write, 1'b0);
				check_value("bus_req.wdata", bus_req.wdata, '0);
			end
			// address range tells the granted source.
			if (fair_mode && instr_req_valid && lar_req_valid) begin
				src = bus_req.addr[9] ? src_lar : src_instr;
				fair_run = (src == fair_last) ? fair_run + 1 : 1;
				fair_last = src;
				if (fair_run > 2) begin
					abort_run("one source waited more than two grants to the other");
				end
			end else begin
				fair_run = 0;
			end
		end
	endtask

	task automatic sample_responses();
		entry_t e;
		if (bus_resp_valid && bus_resp_ready) begin
			void'(bus_pend.pop_front());
			resp_taken = 1'b1;
		end
		if (instr_resp_valid && instr_resp_ready) begin
			if (instr_exp.size() == 0) begin
				abort_run("instr_resp delivered with no request waiting");
			end else begin
				e = instr_exp.pop_front();
				check_value("instr_resp.rdata", instr_resp.rdata, e.data);
			end
		end
		if (lar_resp_valid && lar_resp_ready) begin
			if (lar_exp.size() == 0) begin
				abort_run("lar_resp delivered with no request waiting");
			end else begin
				e = lar_exp.pop_front();
				check_value("lar_resp.rdata", lar_resp.rdata, e.data);
			end
		end
	endtask

	// drive after the edge and sample at the falling edge.
	task automatic step();
		@(posedge clk);
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("run exceeded its cycle limit");
		end
		#1;
		drive_requests();
		drive_bus();
		@(negedge clk);
		check_stalls();
		sample_requests();
		sample_responses();
	endtask

	task automatic drain();
		while (traffic_pending()) begin
			step();
		end
	endtask

	initial begin
		mem_req_t wr;
		arst_n = 1'b0;
		instr_req_valid = 1'b0;
		instr_req = '0;
		lar_req_valid = 1'b0;
		lar_req = '0;
		instr_resp_ready = 1'b0;
		lar_resp_ready = 1'b0;
		bus_req_ready = 1'b0;
		bus_resp_valid = 1'b0;
		bus_resp = '0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		step();
		check_value("bus_req_valid", bus_req_valid, 1'b0);
		check_value("instr_resp_valid", instr_resp_valid, 1'b0);
		check_value("lar_resp_valid", lar_resp_valid, 1'b0);

		// write a line and then fetch it.
		wr.write = 1'b1;
		wr.addr = 32'h5;
		wr.wdata = 64'h0123_4567_89ab_cdef;
		lar_plan.push_back(wr);
		drain();
		instr_plan.push_back(32'h5);
		drain();

		noisy = 1'b1;
		instr_to_send = NUM_RANDOM / 2;
		lar_to_send = NUM_RANDOM / 2;
		drain();

		// the cap must fill while responses are withheld.
		noisy = 1'b0;
		withhold = 1'b1;
		reads_only = 1'b1;
		instr_to_send = NUM_HOLD / 2;
		lar_to_send = NUM_HOLD / 2;
		repeat (24) step();
		check_value("outstanding bus requests", bus_pend.size(), MAX_OUT);
		check_value("bus_req_valid", bus_req_valid, 1'b0);
		withhold = 1'b0;
		reads_only = 1'b0;
		drain();

		fair_mode = 1'b1;
		noisy = 1'b1;
		instr_to_send = NUM_FAIR / 2;
		lar_to_send = NUM_FAIR / 2;
		drain();
		fair_mode = 1'b0;
		noisy = 1'b0;

		repeat (4) step();
		if (bus_pend.size() == 0 && !instr_resp_valid && !lar_resp_valid) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("responses left over at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/pkg_snow64_mem.sv
rtl/snow64_skid_stage.sv
rtl/snow64_mem_bus_guard.sv
rtl/snow64_resp_router.sv
rtl/snow64_mem_accessors.sv
dv/snow64_clk_gen.sv
dv/tb_snow64_mem_accessors.sv

/* Bender.yml */
package:
  name: snow64_mem_accessors

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pkg_snow64_mem.sv
      - rtl/snow64_skid_stage.sv
      - rtl/snow64_mem_bus_guard.sv
      - rtl/snow64_resp_router.sv
      - rtl/snow64_mem_accessors.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/snow64_clk_gen.sv
      - dv/tb_snow64_mem_accessors.sv
